/* rtl/lshape_defs.svh */
`ifndef LSHAPE_DEFS_SVH
`define LSHAPE_DEFS_SVH

// ****************************************
// payload widths
// ****************************************

`define LS_SIDE_W     8   // side payload carried through the pipe
`define LS_UNSTALL_W  8   // payload presented by the outside at pipe exit
`define LS_ENTRY_W    (`LS_SIDE_W + `LS_UNSTALL_W)

// ****************************************
// pipeline and FIFO sizing
// ****************************************

`define LS_DEPTH      4   // cycles from acceptance to FIFO write

// in-flight count spans 0 to LS_DEPTH
`define LS_OCC_W      ($clog2(`LS_DEPTH + 1))

`define LS_FIFO_K     3   // address bits
`define LS_FIFO_DEPTH (1 << `LS_FIFO_K)

`endif

/* rtl/stream_pkg.sv */
`default_nettype none

`include "lshape_defs.svh"

// data types that travel through the join
package stream_pkg;

  // enters at the top of the pipe, leaves LS_DEPTH cycles later
  typedef logic [`LS_SIDE_W-1:0] side_t;

  // cannot be stalled, only sampled at pipe exit
  typedef logic [`LS_UNSTALL_W-1:0] unstall_t;

  // one FIFO word
  // side sits in the upper bits, unstall in the lower bits
  typedef struct packed {
    side_t    side;
    unstall_t unstall;
  } entry_t;

endpackage

`default_nettype wire

/* rtl/flow_pkg.sv */
`default_nettype none

`include "lshape_defs.svh"

// counters used for flow control between the pipe and the FIFO
package flow_pkg;

  // items in flight inside the pipe, 0 to LS_DEPTH
  typedef logic [`LS_OCC_W-1:0] occ_t;

  // FIFO pointers with wrap bit, also the free-slot count
  // one extra bit so that a completely empty FIFO reads as LS_FIFO_DEPTH
  typedef logic [`LS_FIFO_K:0] fill_t;

endpackage

`default_nettype wire

/* rtl/delay_line.sv */
`timescale 1ns/10ps
`default_nettype none

// fixed length shift register for payloads
// no valid bit here, the owner tracks which outputs count
module delay_line #(
  parameter type payload_t = logic [7:0],
  parameter int  LEN       = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t din,
  output payload_t dout
);

  payload_t stage [LEN];

  if (LEN < 1) begin : g_len_check
    $error("delay_line needs at least one stage");
  end

  // ****************************************
  // shift every cycle
  // ****************************************

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < LEN; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < LEN; i++) begin
        stage[i] <= stage[i-1];  // oldest at the high index
      end
    end
  end

  assign dout = stage[LEN-1];

endmodule

`default_nettype wire

/* rtl/valid_stall_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lshape_defs.svh"

// fixed latency valid/stall pipe
// stalls the producer once every free FIFO slot is claimed by an item in flight
module valid_stall_pipe
  import stream_pkg::*, flow_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  // producer side
  input  logic  us_valid,
  input  side_t us_side_data,
  output logic  us_stall,

  // toward the FIFO
  output logic  pipe_valid,
  output side_t pipe_side,

  // credit returned by the FIFO
  input  fill_t free_slots
);

  logic                 accept;
  logic [`LS_DEPTH-1:0] vld_sr;  // bit 0 newest
  occ_t                 occ;

  if (`LS_DEPTH < 2) begin : g_depth_check
    $error("valid chain needs LS_DEPTH of at least 2");
  end

  if ((1 << $bits(occ_t)) <= `LS_DEPTH) begin : g_occ_check
    $error("occ_t too narrow for LS_DEPTH");
  end

  // ****************************************
  // credit check
  // ****************************************

  // every item in flight already owns a slot
  // only accept when one more is still free
  assign us_stall = (fill_t'(occ) >= free_slots);
  assign accept   = us_valid & ~us_stall;

  // ****************************************
  // valid chain and in-flight count
  // ****************************************

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      vld_sr <= '0;
      occ    <= '0;
    end else begin
      vld_sr <= {vld_sr[`LS_DEPTH-2:0], accept};

      case ({accept, pipe_valid})
        2'b10:   occ <= occ + occ_t'(1);  // entry only
        2'b01:   occ <= occ - occ_t'(1);  // exit only
        default: occ <= occ;              // none, or one in and one out
      endcase
    end
  end

  assign pipe_valid = vld_sr[`LS_DEPTH-1];

  // ****************************************
  // side payload
  // ****************************************

  delay_line #(
    .payload_t (side_t),
    .LEN       (`LS_DEPTH)
  ) u_side_dl (
    .clk,
    .rst,
    .din  (us_side_data),
    .dout (pipe_side)
  );

  // ****************************************
  // checks
  // ****************************************

  // the chain holds LS_DEPTH bits, so the count can never go past that
  a_occ_bound: assert property (
    @(posedge clk) disable iff (rst)
    occ <= occ_t'(`LS_DEPTH)
  ) else $error("pipe occupancy %0d above depth", occ);

  // counter and valid chain must agree on the number of items in flight
  a_occ_match: assert property (
    @(posedge clk) disable iff (rst)
    int'(occ) == $countones(vld_sr)
  ) else $error("occupancy %0d does not match valid chain", occ);

endmodule

`default_nettype wire

/* rtl/credit_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

// first word fall through FIFO, 2**K entries
// reports its free slots so that the writer can reserve space ahead of time
module credit_fifo
  import flow_pkg::*;
#(
  parameter type word_t = logic [15:0],
  parameter int  K      = 3
) (
  input  logic  clk,
  input  logic  rst,

  // write side
  input  logic  wr,
  input  word_t wdata,

  // read side
  input  logic  rd,
  output word_t rdata,
  output logic  empty,

  // credit
  output fill_t free_slots
);

  localparam int DEPTH = 1 << K;

  word_t mem [DEPTH];
  fill_t wr_ptr;  // top bit is the wrap bit
  fill_t rd_ptr;
  logic  full;
  logic  do_wr;
  logic  do_rd;

  if (K < 1) begin : g_k_check
    $error("credit_fifo needs K of at least 1");
  end

  if ($bits(fill_t) != K + 1) begin : g_fill_check
    $error("fill_t must be K+1 bits wide");
  end

  // ****************************************
  // status
  // ****************************************

  // same index, wrap bits equal means empty, different means full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr == {~rd_ptr[K], rd_ptr[K-1:0]});

  assign do_wr = wr & ~full;
  assign do_rd = rd & ~empty;

  // ****************************************
  // storage
  // ****************************************

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[K-1:0]] <= wdata;
    end
  end

  assign rdata = mem[rd_ptr[K-1:0]];  // head, valid while empty is low

  // ****************************************
  // pointers and free count
  // ****************************************

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + fill_t'(1);
      if (do_rd) rd_ptr <= rd_ptr + fill_t'(1);
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      free_slots <= fill_t'(DEPTH);
    end else begin
      case ({do_wr, do_rd})
        2'b10:   free_slots <= free_slots - fill_t'(1);
        2'b01:   free_slots <= free_slots + fill_t'(1);
        default: free_slots <= free_slots;  // idle or read with write
      endcase
    end
  end

  // ****************************************
  // checks
  // ****************************************

  // the writer reserves a slot before it commits, so a full FIFO never sees wr
  a_no_wr_full: assert property (
    @(posedge clk) disable iff (rst)
    !(wr && full)
  ) else $error("write into full FIFO");

  a_free_bound: assert property (
    @(posedge clk) disable iff (rst)
    free_slots <= fill_t'(DEPTH)
  ) else $error("free_slots %0d above depth", free_slots);

endmodule

`default_nettype wire

/* rtl/lshape.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lshape_defs.svh"

// L-shaped join
// side data goes down the pipe, unstall data joins it at the exit,
// and the pair lands in a FIFO read by the consumer
module lshape
  import stream_pkg::*, flow_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // producer, valid/stall
  input  logic     us_valid,
  input  side_t    us_side_data,
  output logic     us_stall,

  // sampled in the cycle an item leaves the pipe
  input  unstall_t us_unstall_data,

  // consumer
  input  logic     rdreq,
  output logic     empty,
  output entry_t   ds_data
);

  logic   pipe_valid;
  side_t  pipe_side;
  fill_t  free_slots;
  entry_t wr_entry;

  if ($bits(entry_t) != `LS_ENTRY_W) begin : g_entry_check
    $error("entry_t width does not match LS_ENTRY_W");
  end

  valid_stall_pipe u_pipe (
    .clk,
    .rst,
    .us_valid,
    .us_side_data,
    .us_stall,
    .pipe_valid,
    .pipe_side,
    .free_slots
  );

  // join point, unstall value of this very cycle
  assign wr_entry.side    = pipe_side;
  assign wr_entry.unstall = us_unstall_data;

  credit_fifo #(
    .word_t (entry_t),
    .K      (`LS_FIFO_K)
  ) u_fifo (
    .clk,
    .rst,
    .wr         (pipe_valid),
    .wdata      (wr_entry),
    .rd         (rdreq),
    .rdata      (ds_data),
    .empty,
    .free_slots
  );

endmodule

`default_nettype wire

/* bench/lshape_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lshape_defs.svh"

module lshape_tb
  import stream_pkg::*;
();

  localparam int DEPTH  = `LS_DEPTH;
  localparam int FIFO_N = `LS_FIFO_DEPTH;

  logic     clk;
  logic     rst;
  logic     us_valid;
  side_t    us_side_data;
  logic     us_stall;
  unstall_t us_unstall_data;
  logic     rdreq;
  logic     empty;
  entry_t   ds_data;

  // ****************************************
  // reference model state
  // ****************************************

  side_t    pipe_side_q[$];  // accepted, not yet written
  int       pipe_cyc_q[$];   // edge of acceptance
  side_t    exp_side_q[$];   // expected FIFO contents
  int       exp_cyc_q[$];
  unstall_t hist[$];         // unstall value in front of each edge

  int   seed;
  int   cyc;
  int   checks;
  int   errs;
  int   pair_checks;
  int   pair_errs;
  int   n_acc;
  int   n_pop;
  int   n_both;
  logic hung;

  lshape u_lshape (
    .clk             (clk),
    .rst             (rst),
    .us_valid        (us_valid),
    .us_side_data    (us_side_data),
    .us_stall        (us_stall),
    .us_unstall_data (us_unstall_data),
    .rdreq           (rdreq),
    .empty           (empty),
    .ds_data         (ds_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // one clock: check outputs, drive inputs, advance the model
  task automatic step(input logic v, input logic r);
    logic     exp_stall;
    logic     exp_empty;
    logic     take;
    logic     pop;
    logic     wr;
    side_t    sd;
    unstall_t ud;
    begin
      @(negedge clk);
      exp_stall = (pipe_side_q.size() >= FIFO_N - exp_side_q.size());  // credit rule
      exp_empty = (exp_side_q.size() == 0);
      checks += 2;
      if (us_stall !== exp_stall) begin
        errs++;
        $display("MISMATCH t=%0t us_stall got %0b exp %0b", $time, us_stall, exp_stall);
      end
      if (empty !== exp_empty) begin
        errs++;
        $display("MISMATCH t=%0t empty got %0b exp %0b", $time, empty, exp_empty);
      end

      sd = side_t'($random(seed));
      ud = unstall_t'($random(seed));
      us_valid        = v;
      us_side_data    = sd;
      us_unstall_data = ud;
      rdreq           = r;
      hist.push_back(ud);  // hist[cyc]

      take = v && !us_stall;  // handshake as the DUT sees it
      pop  = r && !exp_empty;
      if (pop) begin
        checks += 2;
        pair_checks++;
        if (ds_data.side !== exp_side_q[0]) begin
          errs++;
          $display("MISMATCH t=%0t ds_data.side got %0h exp %0h",
                   $time, ds_data.side, exp_side_q[0]);
        end
        if (ds_data.unstall !== hist[exp_cyc_q[0] + DEPTH]) begin
          errs++;
          pair_errs++;
          $display("MISMATCH t=%0t ds_data.unstall got %0h exp %0h",
                   $time, ds_data.unstall, hist[exp_cyc_q[0] + DEPTH]);
        end
        void'(exp_side_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end

      wr = 1'b0;
      if (pipe_cyc_q.size() != 0) begin
        wr = (pipe_cyc_q[0] + DEPTH == cyc);  // leaves the pipe at this edge
      end
      if (wr) begin
        exp_side_q.push_back(pipe_side_q.pop_front());
        exp_cyc_q.push_back(pipe_cyc_q.pop_front());
      end
      if (take) begin
        pipe_side_q.push_back(sd);
        pipe_cyc_q.push_back(cyc);
        n_acc++;
      end
      if (r && !empty) begin
        n_pop++;  // pop taken by the DUT at this edge
        if (wr) n_both++;
      end
      cyc++;
    end
  endtask

  task automatic drain();
    int guard;
    begin
      guard = 0;
      while ((exp_side_q.size() != 0 || pipe_side_q.size() != 0) && guard < 100) begin
        step(1'b0, 1'b1);
        guard++;
      end
      if (exp_side_q.size() != 0 || pipe_side_q.size() != 0) begin
        hung = 1'b1;
        $display("timeout: FIFO still holds items after 100 read cycles");
      end else begin
        step(1'b0, 1'b0);  // empty must be back
      end
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    int e0;
    int a0;
    int p0;
    int b0;
    int rnd;
    int guard;

    seed = 32'hf7f9;
    cyc = 0;
    checks = 0;
    errs = 0;
    pair_checks = 0;
    pair_errs = 0;
    n_acc = 0;
    n_pop = 0;
    n_both = 0;
    hung = 1'b0;
    rst = 1'b1;
    us_valid = 1'b0;
    us_side_data = '0;
    us_unstall_data = '0;
    rdreq = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    e0 = errs;
    step(1'b0, 1'b0);
    step(1'b0, 1'b1);  // pop on empty is ignored
    step(1'b0, 1'b0);
    $display("test 1 reset state: %0d errors", errs - e0);

    e0 = errs;
    a0 = n_acc;
    p0 = n_pop;
    repeat (300) begin
      rnd = $random(seed);
      step(rnd[0], rnd[1]);
    end
    drain();
    if (n_pop - p0 != n_acc - a0) begin
      errs++;
      $display("test 2: %0d items accepted but %0d popped", n_acc - a0, n_pop - p0);
    end
    $display("test 2 random traffic: %0d items, %0d errors", n_acc - a0, errs - e0);

    e0 = errs;
    a0 = n_acc;
    guard = 0;
    step(1'b1, 1'b0);
    while (!(us_stall && pipe_side_q.size() == 0) && guard < 50) begin
      step(1'b1, 1'b0);
      guard++;
    end
    if (!(us_stall && pipe_side_q.size() == 0)) begin
      hung = 1'b1;
      $display("timeout: us_stall did not stay high with the FIFO full");
    end
    if (n_acc - a0 != FIFO_N) begin
      errs++;
      $display("test 3: %0d items accepted before stall, expected %0d", n_acc - a0, FIFO_N);
    end
    drain();
    $display("test 3 back-pressure: %0d errors", errs - e0);

    e0 = errs;
    b0 = n_both;
    repeat (DEPTH + 3) step(1'b1, 1'b0);  // partly fill first
    repeat (40) step(1'b1, 1'b1);
    if (n_both == b0) begin
      errs++;
      $display("test 4: no cycle saw a read and a write together");
    end
    drain();
    $display("test 4 read with write: %0d overlaps, %0d errors", n_both - b0, errs - e0);

    $display("test 5 pairing: %0d entries, %0d errors", pair_checks, pair_errs);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errs, hung);
    if (errs == 0 && !hung) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/stream_pkg.sv
rtl/flow_pkg.sv
rtl/delay_line.sv
rtl/valid_stall_pipe.sv
rtl/credit_fifo.sv
rtl/lshape.sv
bench/lshape_tb.sv

/* Makefile */
TOOL   = verilator
FLAGS  = --binary --timing --assert
TOP    = lshape_tb
FLIST  = project.f
OUTDIR = obj_dir

SIM  = $(OUTDIR)/V$(TOP)
SRCS = $(filter-out +%,$(shell cat $(FLIST))) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OUTDIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OUTDIR)
